/* project.f */
+incdir+.
rename_pkg.sv
free_list.sv
rename_table.sv
physical_register_file.sv
rename_top.sv
tb_clock_gen.sv
rename_sva.sv
rename_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_tb
FILELIST  = project.f
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* rename_tb.sv */
`include "rename_macros.svh"

module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0]                 test_id;
        logic                       en;
        rename_pkg::arch_idx_t      src1;
        rename_pkg::arch_idx_t      src2;
        rename_pkg::arch_idx_t      dst;
        logic [4:0]                 wr;             // add, load, mul, div, done.
        logic [4:0][`RN_TAG_W-1:0]  tag;
        logic [4:0][`RN_DATA_W-1:0] data;
        logic                       rel_en;
        rename_pkg::phys_tag_t      rel_tag;
        rename_pkg::data_t          exp_d1;
        rename_pkg::data_t          exp_d2;
        logic                       exp_r1;
        logic                       exp_r2;
        logic                       chk_dst;        // the head tag means nothing on an empty list.
        rename_pkg::phys_tag_t      exp_dst;
        rename_pkg::phys_tag_t      exp_old;
        logic                       exp_stall;
    } step_t;

    logic clk, reset, rename_en, release_en, rename_stall, src1_ready, src2_ready;
    logic add_wr, load_wr, mul_wr, div_wr, done_wr;
    rename_pkg::arch_idx_t src1_arch, src2_arch, dst_arch;
    rename_pkg::phys_tag_t add_tag, load_tag, mul_tag, div_tag, done_tag;
    rename_pkg::phys_tag_t release_tag, dst_tag, old_dst_tag;
    rename_pkg::data_t add_data, load_data, mul_data, div_data, done_data;
    rename_pkg::data_t src1_data, src2_data;

    // reference model of the map, free queue and register file.
    rename_pkg::phys_tag_t m_map [0:`RN_ARCH_REGS-1];
    rename_pkg::phys_tag_t m_free [$];
    rename_pkg::data_t     m_data [0:`RN_PHYS_REGS-1];
    logic                  m_ready [0:`RN_PHYS_REGS-1];

    step_t steps [$];
    step_t cur;
    int    errors, checks, test_errors, test_checks, tests, wd_ns;

    tb_clock_gen i_clock_gen (.clk(clk));

    rename_top i_rename_top (.*);

    bind rename_top rename_sva i_rename_sva (.*);

    function automatic void reset_model();
        m_free.delete();
        for (int i = 0; i < `RN_ARCH_REGS; i++) m_map[i] = rename_pkg::phys_tag_t'(i);
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            m_data[i]  = (i < `RN_ARCH_REGS) ? rename_pkg::data_t'(i) : '0;
            m_ready[i] = 1'b1;
            if (i >= `RN_ARCH_REGS) m_free.push_back(rename_pkg::phys_tag_t'(i));
        end
    endfunction

    function automatic void new_step(input int test_id);
        cur = '0;
        cur.test_id = 8'(test_id);
    endfunction

    // fills in what the DUT should show, then moves the model past the next edge.
    function automatic void push_step();
        logic                  need;
        rename_pkg::phys_tag_t t;
        cur.exp_d1    = m_data[m_map[cur.src1]];
        cur.exp_d2    = m_data[m_map[cur.src2]];
        cur.exp_r1    = m_ready[m_map[cur.src1]];
        cur.exp_r2    = m_ready[m_map[cur.src2]];
        need          = cur.en && (cur.dst != '0);
        cur.chk_dst   = (m_free.size() != 0);
        cur.exp_dst   = cur.chk_dst ? m_free[0] : '0;
        cur.exp_old   = m_map[cur.dst];
        cur.exp_stall = need && !cur.chk_dst;
        for (int k = 0; k < 5; k++) begin
            if (cur.wr[k] && cur.tag[k] != '0) begin
                m_data[cur.tag[k]]  = cur.data[k];
                m_ready[cur.tag[k]] = 1'b1;
            end
        end
        if (need && cur.chk_dst) begin
            t = m_free.pop_front();
            m_map[cur.dst] = t;
            m_ready[t] = 1'b0;                      // allocation beats a same-cycle writeback.
        end
        if (cur.rel_en) m_free.push_back(cur.rel_tag);
        steps.push_back(cur);
    endfunction

    function automatic void build_table();
        int cnt;
        cnt = 0;
        for (int i = 0; i < 32; i++) begin
            new_step(1);
            cur.src1 = rename_pkg::arch_idx_t'(i);
            cur.src2 = rename_pkg::arch_idx_t'(31 - i);
            push_step();
        end
        for (int i = 1; i <= 9; i++) begin
            new_step(2);
            cur.en   = (i < 9);
            cur.dst  = rename_pkg::arch_idx_t'(i < 9 ? i : 0);
            cur.src1 = rename_pkg::arch_idx_t'(i < 9 ? i : 8);
            cur.src2 = rename_pkg::arch_idx_t'(i - 1);   // renamed one step earlier.
            push_step();
        end
        for (int p = 0; p < 5; p++) begin
            new_step(3);
            cur.wr[p]   = 1'b1;
            cur.tag[p]  = m_map[p + 1];
            cur.data[p] = rename_pkg::data_t'($urandom());
            cur.src1    = rename_pkg::arch_idx_t'(p + 1);
            push_step();
            new_step(3);
            cur.src1 = rename_pkg::arch_idx_t'(p + 1);
            cur.src2 = rename_pkg::arch_idx_t'(p + 1);
            push_step();
        end
        for (int s = 0; s < 3; s++) begin
            new_step(4);
            cur.en   = (s == 1);
            cur.dst  = 5'd9;
            cur.src1 = (s == 2) ? 5'd9 : 5'd6;
            cur.src2 = 5'd6;
            for (int p = 0; p < 5 && s < 2; p++) begin
                cur.wr[p]   = 1'b1;
                cur.tag[p]  = (s == 0) ? m_map[6] : m_free[0];
                cur.data[p] = rename_pkg::data_t'($urandom());
            end
            push_step();
        end
        new_step(5);
        cur.en      = 1'b1;                         // x0 asks for no tag.
        cur.wr[0]   = 1'b1;
        cur.data[0] = rename_pkg::data_t'($urandom());
        push_step();
        new_step(5);
        cur.en  = 1'b1;
        cur.dst = 5'd10;
        push_step();
        while (m_free.size() > 0) begin
            new_step(6);
            cur.en   = 1'b1;
            cur.dst  = rename_pkg::arch_idx_t'(cnt % 31 + 1);
            cur.src1 = cur.dst;
            cnt++;
            push_step();
        end
        for (int s = 0; s < 4; s++) begin
            new_step(6);
            cur.en      = (s < 3);
            cur.dst     = (s < 2) ? 5'd5 : 5'd3;
            cur.src1    = cur.dst;
            cur.rel_en  = (s == 1);                 // x12 left tag 12 long ago.
            cur.rel_tag = 8'd12;
            push_step();
        end
    endfunction

    task automatic drive(input step_t s);
        rename_en   = s.en;
        src1_arch   = s.src1;
        src2_arch   = s.src2;
        dst_arch    = s.dst;
        add_wr      = s.wr[0];
        add_tag     = s.tag[0];
        add_data    = s.data[0];
        load_wr     = s.wr[1];
        load_tag    = s.tag[1];
        load_data   = s.data[1];
        mul_wr      = s.wr[2];
        mul_tag     = s.tag[2];
        mul_data    = s.data[2];
        div_wr      = s.wr[3];
        div_tag     = s.tag[3];
        div_data    = s.data[3];
        done_wr     = s.wr[4];
        done_tag    = s.tag[4];
        done_data   = s.data[4];
        release_en  = s.rel_en;
        release_tag = s.rel_tag;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act, input int test_id);
        $display("ERROR test %0d: %s expected %h, got %h", test_id, name, exp, act);
        errors++;
        test_errors++;
    endtask

    initial begin
        void'($urandom(16726));
        reset = 1'b1;
        drive(step_t'('0));
        reset_model();
        build_table();
        wd_ns = (steps.size() + 8 + 25) * 8;        // one cycle per row plus reset and margin.
        fork
            begin
                #(wd_ns);
                $display("timeout: the step table did not finish in time");
                $display("Something failed");
                $finish;
            end
        join_none
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            drive(steps[i]);
            #1;
            if (src1_data !== steps[i].exp_d1)
                report_mismatch("src1_data", steps[i].exp_d1, src1_data, steps[i].test_id);
            if (src2_data !== steps[i].exp_d2)
                report_mismatch("src2_data", steps[i].exp_d2, src2_data, steps[i].test_id);
            if (src1_ready !== steps[i].exp_r1)
                report_mismatch("src1_ready", 32'(steps[i].exp_r1), 32'(src1_ready),
                                steps[i].test_id);
            if (src2_ready !== steps[i].exp_r2)
                report_mismatch("src2_ready", 32'(steps[i].exp_r2), 32'(src2_ready),
                                steps[i].test_id);
            if (old_dst_tag !== steps[i].exp_old)
                report_mismatch("old_dst_tag", 32'(steps[i].exp_old), 32'(old_dst_tag),
                                steps[i].test_id);
            if (rename_stall !== steps[i].exp_stall)
                report_mismatch("rename_stall", 32'(steps[i].exp_stall), 32'(rename_stall),
                                steps[i].test_id);
            if (steps[i].chk_dst && dst_tag !== steps[i].exp_dst)
                report_mismatch("dst_tag", 32'(steps[i].exp_dst), 32'(dst_tag),
                                steps[i].test_id);
            test_checks += steps[i].chk_dst ? 7 : 6;
            if (i == steps.size() - 1 || steps[i + 1].test_id != steps[i].test_id) begin
                $display("test %0d done: %0d checks, %0d errors",
                         steps[i].test_id, test_checks, test_errors);
                checks += test_checks;
                tests++;
                test_checks = 0;
                test_errors = 0;
            end
            @(negedge clk);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* rename_sva.sv */
module rename_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  rename_en,
    input rename_pkg::arch_idx_t dst_arch,
    input rename_pkg::phys_tag_t dst_tag,
    input rename_pkg::phys_tag_t old_dst_tag,
    input logic                  rename_stall,
    input rename_pkg::arch_idx_t src1_arch,
    input rename_pkg::data_t     src1_data,
    input logic                  src1_ready,
    input rename_pkg::arch_idx_t src2_arch,
    input rename_pkg::data_t     src2_data,
    input logic                  src2_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled request leaves the map alone, so a retry of it sees the same old tag.
    stall_keeps_map: assert property (@(posedge clk) disable iff (reset)
        rename_stall |=> (dst_arch != $past(dst_arch) || old_dst_tag == $past(old_dst_tag)))
        else $error("rename table changed under a stall");

    renamed_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        (rename_en && dst_arch != '0 && !rename_stall) |-> dst_tag != '0)
        else $error("tag 0 handed out as a destination");

    // x0 always maps to tag 0, so these reads go through tag 0.
    zero_reg_src1: assert property (@(posedge clk) disable iff (reset)
        src1_arch == '0 |-> (src1_data == '0 && src1_ready))
        else $error("tag 0 read on port 1 is not zero and ready");

    zero_reg_src2: assert property (@(posedge clk) disable iff (reset)
        src2_arch == '0 |-> (src2_data == '0 && src2_ready))
        else $error("tag 0 read on port 2 is not zero and ready");

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period.
    end

endmodule

/* rename_top.sv */
`include "rename_macros.svh"

module rename_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rename_en,
    input  rename_pkg::arch_idx_t src1_arch,
    input  rename_pkg::arch_idx_t src2_arch,
    input  rename_pkg::arch_idx_t dst_arch,
    input  logic                  add_wr,
    input  rename_pkg::phys_tag_t add_tag,
    input  rename_pkg::data_t     add_data,
    input  logic                  load_wr,
    input  rename_pkg::phys_tag_t load_tag,
    input  rename_pkg::data_t     load_data,
    input  logic                  mul_wr,
    input  rename_pkg::phys_tag_t mul_tag,
    input  rename_pkg::data_t     mul_data,
    input  logic                  div_wr,
    input  rename_pkg::phys_tag_t div_tag,
    input  rename_pkg::data_t     div_data,
    input  logic                  done_wr,
    input  rename_pkg::phys_tag_t done_tag,
    input  rename_pkg::data_t     done_data,
    input  logic                  release_en,
    input  rename_pkg::phys_tag_t release_tag,
    output rename_pkg::data_t     src1_data,
    output rename_pkg::data_t     src2_data,
    output logic                  src1_ready,
    output logic                  src2_ready,
    output rename_pkg::phys_tag_t dst_tag,
    output rename_pkg::phys_tag_t old_dst_tag,
    output logic                  rename_stall
);

    rename_pkg::phys_tag_t src1_tag;
    rename_pkg::phys_tag_t src2_tag;
    logic                  list_empty;
    logic                  need_tag;
    logic                  alloc;

    assign need_tag     = rename_en && (dst_arch != '0);   // x0 never gets a tag.
    assign alloc        = need_tag && !list_empty;
    assign rename_stall = need_tag && list_empty;

    free_list i_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .release_en  (release_en),
        .release_tag (release_tag),
        .head_tag    (dst_tag),
        .empty       (list_empty)
    );

    rename_table i_rename_table (
        .clk       (clk),
        .reset     (reset),
        .src1_arch (src1_arch),
        .src2_arch (src2_arch),
        .dst_arch  (dst_arch),
        .remap     (alloc),
        .new_tag   (dst_tag),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .old_tag   (old_dst_tag)
    );

    physical_register_file i_physical_register_file (
        .clk         (clk),
        .reset       (reset),
        .read1_tag   (src1_tag),
        .read2_tag   (src2_tag),
        .invalidate  (alloc),
        .inv_tag     (dst_tag),
        .add_wr      (add_wr),
        .add_tag     (add_tag),
        .add_data    (add_data),
        .load_wr     (load_wr),
        .load_tag    (load_tag),
        .load_data   (load_data),
        .mul_wr      (mul_wr),
        .mul_tag     (mul_tag),
        .mul_data    (mul_data),
        .div_wr      (div_wr),
        .div_tag     (div_tag),
        .div_data    (div_data),
        .done_wr     (done_wr),
        .done_tag    (done_tag),
        .done_data   (done_data),
        .read1_data  (src1_data),
        .read2_data  (src2_data),
        .read1_ready (src1_ready),
        .read2_ready (src2_ready)
    );

endmodule

/* physical_register_file.sv */
`include "rename_macros.svh"

module physical_register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::phys_tag_t read1_tag,
    input  rename_pkg::phys_tag_t read2_tag,
    input  logic                  invalidate,
    input  rename_pkg::phys_tag_t inv_tag,
    input  logic                  add_wr,
    input  rename_pkg::phys_tag_t add_tag,
    input  rename_pkg::data_t     add_data,
    input  logic                  load_wr,
    input  rename_pkg::phys_tag_t load_tag,
    input  rename_pkg::data_t     load_data,
    input  logic                  mul_wr,
    input  rename_pkg::phys_tag_t mul_tag,
    input  rename_pkg::data_t     mul_data,
    input  logic                  div_wr,
    input  rename_pkg::phys_tag_t div_tag,
    input  rename_pkg::data_t     div_data,
    input  logic                  done_wr,
    input  rename_pkg::phys_tag_t done_tag,
    input  rename_pkg::data_t     done_data,
    output rename_pkg::data_t     read1_data,
    output rename_pkg::data_t     read2_data,
    output logic                  read1_ready,
    output logic                  read2_ready
);

    localparam int NUM_WB = 5;

    rename_pkg::data_t     regs  [0:`RN_PHYS_REGS-1];
    logic                  ready [0:`RN_PHYS_REGS-1];

    // writeback ports gathered in priority order, lowest first.
    logic                  wb_wr   [0:NUM_WB-1];
    rename_pkg::phys_tag_t wb_tag  [0:NUM_WB-1];
    rename_pkg::data_t     wb_data [0:NUM_WB-1];

    assign wb_wr   = '{add_wr,   load_wr,   mul_wr,   div_wr,   done_wr};
    assign wb_tag  = '{add_tag,  load_tag,  mul_tag,  div_tag,  done_tag};
    assign wb_data = '{add_data, load_data, mul_data, div_data, done_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                // the architectural registers start out holding their own index.
                regs[i]  <= (i < `RN_ARCH_REGS) ? rename_pkg::data_t'(i) : '0;
                ready[i] <= 1'b1;
            end
        end else begin
            // later ports overwrite earlier ones, so done wins a shared tag.
            for (int k = 0; k < NUM_WB; k++) begin
                if (wb_wr[k] && wb_tag[k] != '0) begin
                    regs[wb_tag[k]]  <= wb_data[k];
                    ready[wb_tag[k]] <= 1'b1;
                end
            end
            // a freshly allocated tag must wait for its own producer.
            if (invalidate && inv_tag != '0) begin
                ready[inv_tag] <= 1'b0;
            end
        end
    end

    // operand reads return the state as of the last clock edge.
    assign read1_data  = regs[read1_tag];
    assign read2_data  = regs[read2_tag];
    assign read1_ready = ready[read1_tag];
    assign read2_ready = ready[read2_tag];

endmodule

/* rename_table.sv */
`include "rename_macros.svh"

module rename_table (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::arch_idx_t src1_arch,
    input  rename_pkg::arch_idx_t src2_arch,
    input  rename_pkg::arch_idx_t dst_arch,
    input  logic                  remap,
    input  rename_pkg::phys_tag_t new_tag,
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output rename_pkg::phys_tag_t old_tag
);

    // current physical home of each architectural register.
    rename_pkg::phys_tag_t map [0:`RN_ARCH_REGS-1];

    // lookups see the mapping from before this cycle's remap.
    assign src1_tag = map[src1_arch];
    assign src2_tag = map[src2_arch];
    assign old_tag  = map[dst_arch];              // handed on so commit can free it later.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map[i] <= rename_pkg::phys_tag_t'(i);   // identity mapping.
            end
        end else if (remap) begin
            // remap is never raised for x0, so entry 0 keeps tag 0.
            map[dst_arch] <= new_tag;
        end
    end

endmodule

/* free_list.sv */
`include "rename_macros.svh"

module free_list (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic                  release_en,
    input  rename_pkg::phys_tag_t release_tag,
    output rename_pkg::phys_tag_t head_tag,
    output logic                  empty
);

    // tags 0 to 31 start out mapped, the rest start out free.
    localparam int DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    rename_pkg::phys_tag_t mem [0:DEPTH-1];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;
    logic                  pop;
    logic                  push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;                            // the buffer is not a power of two deep.
        end
        return ptr + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign head_tag = mem[rd_ptr];                // oldest free tag is offered first.

    assign pop  = alloc && !empty;
    assign push = release_en && !full;            // a full list cannot take more tags back.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= rename_pkg::phys_tag_t'(i + `RN_ARCH_REGS);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;                         // full, so the tail wraps onto the head.
            count  <= CNT_W'(DEPTH);
        end else begin
            if (push) begin
                mem[wr_ptr] <= release_tag;
                wr_ptr      <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // a simultaneous push and pop leave the count unchanged.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

    // tag naming one of the physical registers.
    typedef logic [`RN_TAG_W-1:0] phys_tag_t;

    // index of an architectural register, x0 being the hardwired zero.
    typedef logic [`RN_ARCH_W-1:0] arch_idx_t;

    // one register data word as written back by the execution units.
    typedef logic [`RN_DATA_W-1:0] data_t;

endpackage

/* rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// sizes of the physical register file.
`define RN_PHYS_REGS 256
`define RN_TAG_W 8

// architectural register space, x0 to x31.
`define RN_ARCH_REGS 32
`define RN_ARCH_W 5

// width of one register data word.
`define RN_DATA_W 32

`endif
